//--- design/backend_pkg.sv
package backend_pkg;

    // Graduation list geometry
    localparam int GL_ENTRIES = 8;
    localparam int GL_IDX_W   = 3;              // log2 of GL_ENTRIES
    localparam int GL_CNT_W   = GL_IDX_W + 1;   // Occupancy must reach GL_ENTRIES

    // Datapath
    localparam int DATA_W     = 16;
    localparam int MUL_STAGES = 3;              // Multiplier latency in cycles
    localparam int MUL_HALF_W = DATA_W / 2;     // Operand b is split in two halves

    typedef logic [GL_IDX_W-1:0] gl_index_t;    // One list entry, also the result tag
    typedef logic [GL_CNT_W-1:0] gl_count_t;
    typedef logic [DATA_W-1:0]   data_t;

    // Operation codes, steered by dispatch
    typedef enum logic [1:0] {
        OP_ADD = 2'd0,
        OP_SUB = 2'd1,
        OP_MUL = 2'd2,    // Only one going to the multiplier
        OP_BR  = 2'd3     // Taken when a equals b
    } op_t;

endpackage

//--- design/graduation_list.sv
`timescale 1ns/1ns

module graduation_list import backend_pkg::*; (
    input  logic      clk_i,
    input  logic      rstn_i,
    // Allocation from dispatch
    input  logic      alloc_valid_i,
    input  logic      alloc_pred_i,       // Predicted direction, used by branches
    // Writeback from the units, any order
    input  logic      wb_valid_i,
    input  gl_index_t wb_entry_i,
    input  data_t     wb_data_i,
    input  logic      wb_mispredict_i,
    // Commit side
    input  logic      read_head_i,
    input  logic      flush_i,
    input  gl_index_t flush_entry_i,      // Mispredicted branch, everything younger goes
    output gl_index_t assigned_entry_o,
    output logic      head_valid_o,
    output gl_index_t head_entry_o,
    output data_t     head_data_o,
    output logic      head_mispredict_o,
    output logic      full_o,
    output logic      empty_o
);

    gl_index_t head;                      // Oldest unread entry
    gl_index_t tail;                      // Next free entry
    gl_count_t count;                     // Allocated and not yet read

    logic [GL_ENTRIES-1:0] finished;      // Result has been written back
    logic [GL_ENTRIES-1:0] pred;
    logic [GL_ENTRIES-1:0] mispred;
    data_t                 result [GL_ENTRIES];

    logic      alloc_en;
    logic      read_en;
    gl_index_t flush_tail;
    gl_count_t flush_count;

    assign full_o           = (count == gl_count_t'(GL_ENTRIES));
    assign empty_o          = (count == '0);
    assign assigned_entry_o = tail;       // Handed out in the accepting cycle

    assign alloc_en = alloc_valid_i & ~full_o & ~flush_i;
    // Head leaves only once its result is in
    assign read_en  = read_head_i & ~empty_o & finished[head];

    // Recovery point is the slot right after the branch
    assign flush_tail  = flush_entry_i + gl_index_t'(1);
    assign flush_count = (flush_tail >= head)
                       ? {1'b0, flush_tail} - {1'b0, head}
                       : gl_count_t'(GL_ENTRIES) - {1'b0, head} + {1'b0, flush_tail};

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (flush_i) begin
            // Head already sits past the branch, a read now is squashed by commit
            tail  <= flush_tail;
            count <= flush_count;       // Wraps back to zero here
        end else begin
            head  <= head + gl_index_t'(read_en);
            tail  <= tail + gl_index_t'(alloc_en);
            count <= count + gl_count_t'(alloc_en) - gl_count_t'(read_en);
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            finished     <= '0;
            head_valid_o <= 1'b0;
        end else begin
            head_valid_o <= read_en;    // Head shows up one cycle after its read
            if (alloc_en) begin
                finished[tail] <= 1'b0;
            end
            if (wb_valid_i) begin
                finished[wb_entry_i] <= 1'b1;
            end
        end
    end

    // Entry payload
    always_ff @(posedge clk_i) begin
        if (alloc_en) begin
            pred[tail] <= alloc_pred_i;
        end
        if (wb_valid_i) begin
            result[wb_entry_i]  <= wb_data_i;
            // Flag stands only if the outcome really differs from the stored guess
            mispred[wb_entry_i] <= wb_mispredict_i & (wb_data_i[0] != pred[wb_entry_i]);
        end
    end

    always_ff @(posedge clk_i) begin
        if (read_en) begin
            head_entry_o      <= head;
            head_data_o       <= result[head];
            head_mispredict_o <= mispred[head];
        end
    end

endmodule

//--- design/dispatch_stage.sv
`timescale 1ns/1ns

module dispatch_stage import backend_pkg::*; (
    input  logic      clk_i,
    input  logic      rstn_i,
    // Incoming instruction, operands already read
    input  logic      instr_valid_i,
    input  op_t       instr_op_i,
    input  data_t     instr_a_i,
    input  data_t     instr_b_i,
    input  logic      instr_pred_i,
    // Stall sources
    input  logic      full_i,
    input  logic      flush_i,
    input  logic      mul_stage2_busy_i,
    input  gl_index_t assigned_entry_i,   // Tail of the list
    output logic      ready_o,
    output logic      alloc_valid_o,
    output logic      alloc_pred_o,
    // Issue to the units
    output logic      alu_issue_o,
    output logic      mul_issue_o,
    output op_t       issue_op_o,
    output data_t     issue_a_o,
    output data_t     issue_b_o,
    output gl_index_t issue_entry_o
);

    logic        is_mul;
    logic        wb_clash;
    logic        accept;

    assign is_mul   = (instr_op_i == OP_MUL);
    // ALU result would land in the same cycle as the product now in stage 2
    assign wb_clash = mul_stage2_busy_i & ~is_mul;

    assign ready_o = ~full_i & ~flush_i & ~wb_clash;
    assign accept  = instr_valid_i & ready_o;

    assign alloc_valid_o = accept;
    assign alloc_pred_o  = instr_pred_i;

    // Steering, same cycle as allocation
    assign alu_issue_o   = accept & ~is_mul;  // Add, sub and branch
    assign mul_issue_o   = accept & is_mul;
    assign issue_op_o    = instr_op_i;
    assign issue_a_o     = instr_a_i;
    assign issue_b_o     = instr_b_i;
    assign issue_entry_o = assigned_entry_i;  // Tag follows the op through the unit

endmodule

//--- design/alu_unit.sv
`timescale 1ns/1ns

module alu_unit import backend_pkg::*; (
    input  logic      clk_i,
    input  logic      rstn_i,
    input  logic      issue_i,
    input  op_t       op_i,
    input  data_t     a_i,
    input  data_t     b_i,
    input  logic      pred_i,       // Predicted taken
    input  gl_index_t entry_i,
    input  logic      flush_i,
    output logic      wb_valid_o,
    output gl_index_t wb_entry_o,
    output data_t     wb_data_o,
    output logic      wb_mispredict_o
);

    data_t res;
    logic  taken;
    logic  misp;

    assign taken = (a_i == b_i);    // Branch compare

    always_comb begin
        misp = 1'b0;
        case (op_i)
            OP_ADD: res = a_i + b_i;
            OP_SUB: res = a_i - b_i;
            OP_BR: begin
                res  = {{(DATA_W-1){1'b0}}, taken};   // Outcome in bit 0
                misp = (taken != pred_i);
            end
            default: res = '0;      // Products come from the multiplier
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            wb_valid_o <= 1'b0;
        end else begin
            wb_valid_o <= issue_i & ~flush_i;   // Flush kills the pending result
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue_i) begin
            wb_entry_o      <= entry_i;
            wb_data_o       <= res;
            wb_mispredict_o <= misp;
        end
    end

endmodule

//--- design/mul_unit.sv
`timescale 1ns/1ns

module mul_unit import backend_pkg::*; (
    input  logic      clk_i,
    input  logic      rstn_i,
    input  logic      issue_i,
    input  data_t     a_i,
    input  data_t     b_i,
    input  gl_index_t entry_i,
    input  logic      flush_i,
    output logic      wb_valid_o,
    output gl_index_t wb_entry_o,
    output data_t     wb_data_o,
    output logic      stage2_busy_o    // Next cycle carries a product out
);

    logic [MUL_STAGES-1:0] vld;        // Valid per stage, bit 0 is stage 1
    gl_index_t             tag [MUL_STAGES];

    data_t                 pp_lo;      // a times low half of b
    logic [MUL_HALF_W-1:0] pp_hi;      // Only the bits that land below DATA_W
    data_t                 s1_acc;
    logic [MUL_HALF_W-1:0] s1_a_lo;
    logic [MUL_HALF_W-1:0] s1_b_hi;
    data_t                 s2_acc;

    assign pp_lo = a_i * {{MUL_HALF_W{1'b0}}, b_i[MUL_HALF_W-1:0]};
    assign pp_hi = s1_a_lo * s1_b_hi;  // Truncated, upper bits shift out anyway

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            vld <= '0;
        end else if (flush_i) begin
            vld <= '0;                 // Every in-flight product is dropped
        end else begin
            vld <= {vld[MUL_STAGES-2:0], issue_i};
        end
    end

    // Tags ride along with the data
    always_ff @(posedge clk_i) begin
        if (issue_i) begin
            tag[0] <= entry_i;
        end
        for (int s = 1; s < MUL_STAGES; s++) begin
            if (vld[s-1]) begin
                tag[s] <= tag[s-1];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue_i) begin            // Stage 1, low partial product
            s1_acc  <= pp_lo;
            s1_a_lo <= a_i[MUL_HALF_W-1:0];
            s1_b_hi <= b_i[DATA_W-1:MUL_HALF_W];
        end
        if (vld[0]) begin             // Stage 2, add shifted high partial product
            s2_acc <= s1_acc + {pp_hi, {MUL_HALF_W{1'b0}}};
        end
        if (vld[1]) begin             // Stage 3, output register
            wb_data_o <= s2_acc;
        end
    end

    assign wb_valid_o    = vld[MUL_STAGES-1];
    assign wb_entry_o    = tag[MUL_STAGES-1];
    assign stage2_busy_o = vld[MUL_STAGES-2];

endmodule

//--- design/commit_stage.sv
`timescale 1ns/1ns

module commit_stage import backend_pkg::*; (
    input  logic      clk_i,
    input  logic      rstn_i,
    input  logic      empty_i,
    // Head presented by the list, one cycle after the read
    input  logic      head_valid_i,
    input  gl_index_t head_entry_i,
    input  data_t     head_data_i,
    input  logic      head_mispredict_i,
    output logic      read_head_o,
    output logic      flush_o,
    output gl_index_t flush_entry_o,
    output logic      commit_valid_o,
    output data_t     commit_result_o,
    output gl_index_t commit_entry_o,
    output logic      redirect_o
);

    logic squash;    // Head read during the flush is on the wrong path

    // Keep reading while anything is left, except right after a flush
    assign read_head_o = ~empty_i & ~squash;

    // Retire in order, at most one per cycle
    assign commit_valid_o  = head_valid_i & ~squash;
    assign commit_result_o = head_data_i;
    assign commit_entry_o  = head_entry_i;

    // Mispredicted branch retires itself and throws away all younger work
    assign flush_o       = commit_valid_o & head_mispredict_i;
    assign flush_entry_o = head_entry_i;
    assign redirect_o    = flush_o;     // Fetch restarts on the right path

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            squash <= 1'b0;
        end else begin
            squash <= flush_o;          // Covers exactly the cycle after the flush
        end
    end

endmodule

//--- design/backend_top.sv
`timescale 1ns/1ns

module backend_top import backend_pkg::*; (
    input  logic      clk_i,
    input  logic      rstn_i,
    input  logic      instr_valid_i,
    input  op_t       instr_op_i,
    input  data_t     instr_a_i,
    input  data_t     instr_b_i,
    input  logic      instr_pred_i,
    output logic      ready_o,
    output logic      commit_valid_o,
    output data_t     commit_result_o,
    output gl_index_t commit_entry_o,
    output logic      redirect_o
);

    // Allocation
    gl_index_t assigned_entry;
    logic      gl_full;
    logic      gl_empty;
    logic      alloc_valid;
    logic      alloc_pred;

    // Issue
    logic      alu_issue;
    logic      mul_issue;
    op_t       issue_op;
    data_t     issue_a;
    data_t     issue_b;
    gl_index_t issue_entry;
    logic      mul_stage2_busy;

    // Unit results
    logic      alu_wb_valid;
    gl_index_t alu_wb_entry;
    data_t     alu_wb_data;
    logic      alu_wb_mispredict;
    logic      mul_wb_valid;
    gl_index_t mul_wb_entry;
    data_t     mul_wb_data;

    // Single writeback port of the list
    logic      wb_valid;
    gl_index_t wb_entry;
    data_t     wb_data;
    logic      wb_mispredict;

    // Commit
    logic      read_head;
    logic      head_valid;
    gl_index_t head_entry;
    data_t     head_data;
    logic      head_mispredict;
    logic      flush;
    gl_index_t flush_entry;

    // Dispatch keeps both units from finishing together, ALU takes priority anyway
    assign wb_valid      = alu_wb_valid | mul_wb_valid;
    assign wb_entry      = alu_wb_valid ? alu_wb_entry : mul_wb_entry;
    assign wb_data       = alu_wb_valid ? alu_wb_data : mul_wb_data;
    assign wb_mispredict = alu_wb_valid & alu_wb_mispredict;   // Products never mispredict

    graduation_list u_gl (
        .clk_i(clk_i), .rstn_i(rstn_i),
        .alloc_valid_i(alloc_valid), .alloc_pred_i(alloc_pred),
        .wb_valid_i(wb_valid), .wb_entry_i(wb_entry),
        .wb_data_i(wb_data), .wb_mispredict_i(wb_mispredict),
        .read_head_i(read_head), .flush_i(flush), .flush_entry_i(flush_entry),
        .assigned_entry_o(assigned_entry),
        .head_valid_o(head_valid), .head_entry_o(head_entry),
        .head_data_o(head_data), .head_mispredict_o(head_mispredict),
        .full_o(gl_full), .empty_o(gl_empty)
    );

    dispatch_stage u_dispatch (
        .clk_i(clk_i), .rstn_i(rstn_i),
        .instr_valid_i(instr_valid_i), .instr_op_i(instr_op_i),
        .instr_a_i(instr_a_i), .instr_b_i(instr_b_i), .instr_pred_i(instr_pred_i),
        .full_i(gl_full), .flush_i(flush), .mul_stage2_busy_i(mul_stage2_busy),
        .assigned_entry_i(assigned_entry),
        .ready_o(ready_o), .alloc_valid_o(alloc_valid), .alloc_pred_o(alloc_pred),
        .alu_issue_o(alu_issue), .mul_issue_o(mul_issue), .issue_op_o(issue_op),
        .issue_a_o(issue_a), .issue_b_o(issue_b), .issue_entry_o(issue_entry)
    );

    alu_unit u_alu (
        .clk_i(clk_i), .rstn_i(rstn_i),
        .issue_i(alu_issue), .op_i(issue_op), .a_i(issue_a), .b_i(issue_b),
        .pred_i(alloc_pred), .entry_i(issue_entry), .flush_i(flush),
        .wb_valid_o(alu_wb_valid), .wb_entry_o(alu_wb_entry),
        .wb_data_o(alu_wb_data), .wb_mispredict_o(alu_wb_mispredict)
    );

    mul_unit u_mul (
        .clk_i(clk_i), .rstn_i(rstn_i),
        .issue_i(mul_issue), .a_i(issue_a), .b_i(issue_b),
        .entry_i(issue_entry), .flush_i(flush),
        .wb_valid_o(mul_wb_valid), .wb_entry_o(mul_wb_entry),
        .wb_data_o(mul_wb_data), .stage2_busy_o(mul_stage2_busy)
    );

    commit_stage u_commit (
        .clk_i(clk_i), .rstn_i(rstn_i), .empty_i(gl_empty),
        .head_valid_i(head_valid), .head_entry_i(head_entry),
        .head_data_i(head_data), .head_mispredict_i(head_mispredict),
        .read_head_o(read_head), .flush_o(flush), .flush_entry_o(flush_entry),
        .commit_valid_o(commit_valid_o), .commit_result_o(commit_result_o),
        .commit_entry_o(commit_entry_o), .redirect_o(redirect_o)
    );

endmodule

//--- dv/backend_assert.sv
`timescale 1ns/1ns

module backend_assert (
    input logic clk_i,
    input logic rstn_i,
    input logic ready_i,
    input logic full_i,
    input logic commit_valid_i,
    input logic redirect_i,
    input logic alu_wb_valid_i,
    input logic mul_wb_valid_i,
    input logic flush_i
);

    int full_fails     = 0;
    int redirect_fails = 0;
    int wb_fails       = 0;
    int flush_fails    = 0;
    int fail_cnt;                       // Summed up by the testbench at the end

    assign fail_cnt = full_fails + redirect_fails + wb_fails + flush_fails;

    assert property (@(posedge clk_i) disable iff (!rstn_i) full_i |-> !ready_i) else begin
        $error("ready_o is high while the graduation list is full");
        full_fails++;
    end

    // Redirect only comes with the branch retiring
    assert property (@(posedge clk_i) disable iff (!rstn_i) redirect_i |-> commit_valid_i) else begin
        $error("redirect_o without commit_valid_o");
        redirect_fails++;
    end

    assert property (@(posedge clk_i) disable iff (!rstn_i) !(alu_wb_valid_i && mul_wb_valid_i))
        else begin
            $error("ALU and multiplier write back in the same cycle");
            wb_fails++;
        end

    assert property (@(posedge clk_i) disable iff (!rstn_i) flush_i |=> !flush_i) else begin
        $error("flush held for more than one cycle");
        flush_fails++;
    end

endmodule

bind backend_top backend_assert u_assert (
    .clk_i(clk_i), .rstn_i(rstn_i), .ready_i(ready_o), .full_i(gl_full),
    .commit_valid_i(commit_valid_o), .redirect_i(redirect_o),
    .alu_wb_valid_i(alu_wb_valid), .mul_wb_valid_i(mul_wb_valid), .flush_i(flush)
);

//--- dv/backend_tb.sv
`timescale 1ns/1ns

module backend_tb import backend_pkg::*; ();

    localparam int N_INSTR    = 108;                // 24 + 32 + 20 + 32 over the tests
    localparam int MAX_CYCLES = 40 * N_INSTR;

    logic      clk_i = 1'b0;
    logic      rstn_i;
    logic      instr_valid_i;
    op_t       instr_op_i;
    data_t     instr_a_i;
    data_t     instr_b_i;
    logic      instr_pred_i;
    logic      ready_o;
    logic      commit_valid_o;
    data_t     commit_result_o;
    gl_index_t commit_entry_o;
    logic      redirect_o;

    logic [DATA_W+1:0] exp_q [$];                   // {squashed, mispredict, result}
    int        seed       = 32'h5c08c7b7;
    string     test_name  = "reset";
    int        live_cnt   = 0;                      // Right-path instructions not yet retired
    logic      wrong_path = 1'b0;                   // Mispredicted branch still in flight
    gl_index_t next_entry = '0;
    int        cycles     = 0;
    int        checks     = 0;
    int        errors     = 0;
    int        commits    = 0;
    int        tests      = 0;
    int        c0;                                  // Commits at test start
    int        e0;                                  // Errors at test start

    backend_top uut (.*);

    always #2 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run not finished after %0d cycles", MAX_CYCLES);
            $display("=== FAIL ===");
            $finish;
        end
    end

    function automatic data_t model_result(input op_t op, input data_t a, input data_t b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_MUL:  return a * b;                  // Low half of the product
            default: return (a == b) ? data_t'(1) : data_t'(0);   // Taken flag
        endcase
    endfunction

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        assert (expected == actual) else begin
            $display("mismatch %s %s: expected %0h, actual %0h",
                     test_name, what, expected, actual);
            errors++;
        end
    endtask

    // Reference queue, sampled mid-cycle
    always @(negedge clk_i) begin
        logic [DATA_W+1:0] e;
        logic              misp;
        if (rstn_i) begin
            if (commit_valid_o) begin
                while (exp_q.size() > 0 && exp_q[0][DATA_W+1]) begin
                    e = exp_q.pop_front();          // Flushed, never retires
                end
                if (exp_q.size() == 0) begin
                    $display("error in %s: entry %0d committed with nothing outstanding",
                             test_name, commit_entry_o);
                    errors++;
                end else begin
                    e = exp_q.pop_front();
                    check("result", 32'(e[DATA_W-1:0]), 32'(commit_result_o));
                    check("redirect", 32'(e[DATA_W]), 32'(redirect_o));
                    live_cnt--;
                end
                check("entry", 32'(next_entry), 32'(commit_entry_o));
                next_entry++;                       // Wraps with the list
                commits++;
            end
            if (redirect_o) begin
                wrong_path = 1'b0;
            end
            if (instr_valid_i && ready_o) begin
                misp = (instr_op_i == OP_BR) && ((instr_a_i == instr_b_i) != instr_pred_i);
                exp_q.push_back({wrong_path, misp,
                                 model_result(instr_op_i, instr_a_i, instr_b_i)});
                if (!wrong_path) begin
                    live_cnt++;
                    wrong_path = misp;
                end
            end
        end
    end

    // Holds the instruction until dispatch takes it
    task automatic send(input op_t op, input data_t a, input data_t b, input logic pred);
        instr_valid_i = 1'b1;
        instr_op_i    = op;
        instr_a_i     = a;
        instr_b_i     = b;
        instr_pred_i  = pred;
        @(negedge clk_i);
        while (!ready_o) begin
            @(negedge clk_i);
        end
        @(posedge clk_i);
        #1;
        instr_valid_i = 1'b0;
    endtask

    task automatic send_random(input int mul_w, input bit br_on, input bit misp_on);
        int    r;
        op_t   op;
        data_t a;
        data_t b;
        logic  pred;
        r = $random(seed);
        a = data_t'($random(seed));
        b = r[2] ? a : data_t'($random(seed));      // Equal operands now and then
        if (((r >> 4) & 15) < mul_w) begin
            op = OP_MUL;
        end else if (br_on && ((r >> 8) & 3) == 0) begin
            op = OP_BR;
        end else begin
            op = ((r >> 10) & 1) ? OP_SUB : OP_ADD;
        end
        pred = (a == b);
        if (misp_on && ((r >> 13) & 7) == 0) begin
            pred = ~pred;                           // Wrong guess
        end
        send(op, a, b, pred);
    endtask

    task automatic drain();
        @(posedge clk_i);
        while (live_cnt != 0) begin
            @(posedge clk_i);
        end
        #1;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        c0 = commits;
        e0 = errors;
    endtask

    task automatic finish_test();
        $display("test %-12s %0d commits, %0d errors", test_name, commits - c0, errors - e0);
        tests++;
    endtask

    initial begin
        rstn_i        = 1'b0;
        instr_valid_i = 1'b0;
        instr_op_i    = OP_ADD;
        instr_a_i     = '0;
        instr_b_i     = '0;
        instr_pred_i  = 1'b0;
        repeat (2) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;

        start_test("reset");
        repeat (4) begin
            @(negedge clk_i);
            check("ready_o", 1, 32'(ready_o));
            check("commit_valid_o", 0, 32'(commit_valid_o));
            check("redirect_o", 0, 32'(redirect_o));
        end
        @(posedge clk_i);
        #1;
        finish_test();

        start_test("in_order");
        repeat (24) send_random(0, 1'b0, 1'b0);
        drain();
        finish_test();

        start_test("out_of_order");
        repeat (32) send_random(8, 1'b1, 1'b0);    // Mul mixed with ALU, hits the clash stall
        drain();
        finish_test();

        start_test("full_stall");
        repeat (20) send(OP_MUL, data_t'($random(seed)), data_t'($random(seed)), 1'b0);
        drain();
        finish_test();

        start_test("mispredict");
        send(OP_BR, 16'h1234, 16'h1234, 1'b0);      // Taken, guessed not taken
        repeat (31) send_random(5, 1'b1, 1'b1);
        drain();
        finish_test();

        repeat (8) @(posedge clk_i);                // Quiet window for stray commits
        $display("summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
                 tests, checks, errors, uut.u_assert.fail_cnt);
        if (errors == 0 && uut.u_assert.fail_cnt == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- files.f
design/backend_pkg.sv
design/graduation_list.sv
design/dispatch_stage.sv
design/alu_unit.sv
design/mul_unit.sv
design/commit_stage.sv
design/backend_top.sv
dv/backend_assert.sv
dv/backend_tb.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module backend_tb -f files.f -o vbackend_tb \
    && ./obj_dir/vbackend_tb +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "=== PASS ===" sim.log && ! grep -q "=== FAIL ===" sim.log \
    && echo "simulation passed" || { echo "simulation failed"; exit 1; }
